// ==== bench/bridge_patterns.txt ====
# W addr data err | R addr expected_data expected_err (apb, hex)
# H host_addr expected_core_addr | D dram_addr expected_ps_addr expected_range_flag
R 00 00000000 0
R 08 00000000 0
W 00 00000001 0
W 04 00000001 0
R 04 00000001 0
W 08 10000000 0
R 08 10000000 0
H 00001000 80001000
H 20000000 A0000000
H 20000004 00000004
H 3FFFFFFC 1FFFFFFC
D 80000040 10000040 0
D 83FFFFFC 13FFFFFC 0
D 84000000 14000000 0
D 84000004 14000004 1
D BF800010 4F800010 1
D 92000000 22000000 1
R 10 00000181 0
R 14 00000010 0
R 18 00000000 0
R 1C 80000000 0
W 14 FFFFFFFF 1
R 14 00000010 0
W 0C 12345678 1
R 0C 00000000 1
R 20 00000000 1
R 00 00000001 0
R 08 10000000 0
W 20 00000001 0
R 10 00000000 0
R 1C 00000000 0
D 80800000 10800000 0
R 10 00000002 0
W 00 00000000 0
R 10 00000000 0

// ==== verilog.f ====
source/bridge_pkg.sv
source/bridge_csr_decode.sv
source/bridge_addr_translate.sv
source/bridge_mem_profiler.sv
source/zynq_bridge_top.sv
bench/zynq_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module zynq_bridge_tb -o zynq_bridge_sim
./obj_dir/zynq_bridge_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

// ==== bench/zynq_bridge_tb.sv ====
`timescale 1ns/1ps

module zynq_bridge_tb
   import bridge_pkg::*;
   ();

   localparam int unsigned clk_period_c    = 4;
   localparam int unsigned cycles_per_op_c = 20;

   // clock starts low so the first falling edge is a real one
   logic       aclk = 1'b0;
   logic       rst_n;
   logic       psel;
   logic       penable;
   logic       pwrite;
   apb_addr_t  paddr;
   csr_word_t  pwdata;
   csr_word_t  prdata;
   logic       pready;
   logic       pslverr;
   logic       host_addr_v;
   host_addr_t host_addr;
   logic       core_addr_v;
   core_addr_t core_addr;
   logic       dram_v;
   dram_addr_u dram_addr;
   logic       ps_addr_v;
   ps_addr_t   ps_addr;
   logic       dram_range_err;
   logic       core_reset_n;

   int unsigned errors = 0;
   int unsigned tests  = 0;
   int unsigned failed = 0;
   int unsigned n_ops  = 0;

   // one entry per pattern line with the fields in file order
   byte         op_q[$];
   logic [31:0] a_q[$];
   logic [31:0] b_q[$];
   logic [31:0] c_q[$];

   zynq_bridge_top #(.dram_limit_p(64*1024*1024)) UUT
     (.aclk_i(aclk), .rst_n_i(rst_n)
     ,.psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr)
     ,.pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
     ,.host_addr_v_i(host_addr_v), .host_addr_i(host_addr)
     ,.core_addr_v_o(core_addr_v), .core_addr_o(core_addr)
     ,.dram_v_i(dram_v), .dram_addr_i(dram_addr), .ps_addr_v_o(ps_addr_v)
     ,.ps_addr_o(ps_addr), .dram_range_err_o(dram_range_err)
     ,.core_reset_n_o(core_reset_n));

   initial
   begin
      forever #(clk_period_c / 2) aclk = ~aclk;
   end

   task automatic check_word(input string name, input csr_word_t exp, input csr_word_t act);
      if (act !== exp)
      begin
         $display("ERROR %s expected %h got %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_core_addr(input string name, input core_addr_t exp,
                                  input core_addr_t act);
      if (act !== exp)
      begin
         $display("ERROR %s expected %h got %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_ps_addr(input string name, input ps_addr_t exp, input ps_addr_t act);
      if (act !== exp)
      begin
         $display("ERROR %s expected %h got %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("ERROR %s expected %h got %h", name, exp, act);
         errors++;
      end
   endtask

   // a two-cycle transfer is called on a falling edge and returns on one
   task automatic apb_transfer(input logic wr, input apb_addr_t addr, input csr_word_t data,
                               input logic exp_err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wr ? data : '0;
      @(negedge aclk);
      penable = 1'b1;
      // access phase outputs are combinational so they are sampled well before the rising edge
      #(clk_period_c / 4);
      check_flag("pready_o", 1'b1, pready);
      check_flag("pslverr_o", exp_err, pslverr);
      if (!wr)
         check_word("prdata_o", data, prdata);
      @(negedge aclk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      // a good write of the run bit moves the core reset with it
      if (wr && !exp_err && addr == REG_RUN)
         check_flag("core_reset_n_o", data[0], core_reset_n);
   endtask

   // the translated address shows up one cycle after the request
   task automatic host_translate(input host_addr_t addr, input core_addr_t exp);
      host_addr_v = 1'b1;
      host_addr   = addr;
      @(negedge aclk);
      host_addr_v = 1'b0;
      check_flag("core_addr_v_o", 1'b1, core_addr_v);
      check_core_addr("core_addr_o", exp, core_addr);
   endtask

   task automatic dram_access(input core_addr_t addr, input ps_addr_t exp, input logic exp_err);
      dram_v        = 1'b1;
      dram_addr.raw = addr;
      @(negedge aclk);
      dram_v = 1'b0;
      check_flag("ps_addr_v_o", 1'b1, ps_addr_v);
      check_ps_addr("ps_addr_o", exp, ps_addr);
      check_flag("dram_range_err_o", exp_err, dram_range_err);
   endtask

   // the run may take at most a fixed number of cycles per pattern line
   initial
   begin
      wait (n_ops != 0);
      #(n_ops * cycles_per_op_c * clk_period_c);
      $display("timeout: patterns still running after %0d cycles", n_ops * cycles_per_op_c);
      $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      int          fd;
      int          code;
      byte         op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      string       rest;
      int unsigned gap;
      int unsigned prev;
      gap         = $urandom(56);
      rst_n       = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      host_addr_v = 1'b0;
      host_addr   = '0;
      dram_v      = 1'b0;
      dram_addr   = '0;
      fd = $fopen("bench/bridge_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the pattern file bench/bridge_patterns.txt");
         errors++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            code = $fscanf(fd, " %c", op);
            if (code != 1)
               break;
            c = '0;
            // lines starting with a hash describe the columns
            if (op == "#")
               code = $fgets(rest, fd);
            else
            begin
               if (op == "H")
                  code = $fscanf(fd, "%h %h", a, b) + 1;
               else
                  code = $fscanf(fd, "%h %h %h", a, b, c);
               if (code != 3)
               begin
                  $display("pattern line %0d is missing fields", op_q.size() + 1);
                  errors++;
               end
               op_q.push_back(op);
               a_q.push_back(a);
               b_q.push_back(b);
               c_q.push_back(c);
            end
         end
         $fclose(fd);
         n_ops = op_q.size();
      end
      repeat (2) @(negedge aclk);
      rst_n = 1'b1;
      // everything comes out of reset quiet with the core held
      prev = errors;
      check_flag("core_reset_n_o", 1'b0, core_reset_n);
      check_flag("core_addr_v_o", 1'b0, core_addr_v);
      check_flag("ps_addr_v_o", 1'b0, ps_addr_v);
      check_flag("dram_range_err_o", 1'b0, dram_range_err);
      check_flag("pslverr_o", 1'b0, pslverr);
      tests++;
      failed += (errors != prev) ? 1 : 0;
      $display("test %0d reset state: %s", tests, (errors == prev) ? "ok" : "failed");
      for (int i = 0; i < n_ops; i++)
      begin
         gap = $urandom % 4;
         repeat (gap) @(negedge aclk);
         prev = errors;
         case (op_q[i])
            "W": apb_transfer(1'b1, apb_addr_t'(a_q[i]), b_q[i], c_q[i][0]);
            "R": apb_transfer(1'b0, apb_addr_t'(a_q[i]), b_q[i], c_q[i][0]);
            "H": host_translate(host_addr_t'(a_q[i]), b_q[i]);
            "D": dram_access(a_q[i], b_q[i], c_q[i][0]);
            default:
            begin
               $display("unknown operation %c in the pattern file", op_q[i]);
               errors++;
            end
         endcase
         tests++;
         failed += (errors != prev) ? 1 : 0;
         $display("test %0d %c %h %h: %s", tests, op_q[i], a_q[i], b_q[i],
                  (errors == prev) ? "ok" : "failed");
      end
      $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== source/zynq_bridge_top.sv ====
`timescale 1ns/1ps

module zynq_bridge_top
   import bridge_pkg::*;
   #(
     // bytes of host dram that the core is expected to use
     parameter int unsigned dram_limit_p = 64*1024*1024
   )
   (
    input  logic       aclk_i
   ,input  logic       rst_n_i

    // apb control register port
   ,input  logic       psel_i
   ,input  logic       penable_i
   ,input  logic       pwrite_i
   ,input  apb_addr_t  paddr_i
   ,input  csr_word_t  pwdata_i
   ,output csr_word_t  prdata_o
   ,output logic       pready_o
   ,output logic       pslverr_o

    // host window translation
   ,input  logic       host_addr_v_i
   ,input  host_addr_t host_addr_i
   ,output logic       core_addr_v_o
   ,output core_addr_t core_addr_o

    // core dram rebasing
   ,input  logic       dram_v_i
   ,input  dram_addr_u dram_addr_i
   ,output logic       ps_addr_v_o
   ,output ps_addr_t   ps_addr_o
   ,output logic       dram_range_err_o

    // core reset, low true
   ,output logic       core_reset_n_o
   );

   logic       core_run;
   ps_addr_t   base_addr;
   logic [1:0] prof_sel;
   logic       prof_clr;
   csr_word_t  prof_word;

   // register decode
   bridge_csr_decode csr
     (.aclk_i         (aclk_i)
     ,.rst_n_i        (rst_n_i)
     ,.psel_i         (psel_i)
     ,.penable_i      (penable_i)
     ,.pwrite_i       (pwrite_i)
     ,.paddr_i        (paddr_i)
     ,.pwdata_i       (pwdata_i)
     ,.prdata_o       (prdata_o)
     ,.pready_o       (pready_o)
     ,.pslverr_o      (pslverr_o)
     ,.prof_word_i    (prof_word)
     ,.core_run_o     (core_run)
     ,.base_addr_o    (base_addr)
     ,.prof_sel_o     (prof_sel)
     ,.prof_clr_o     (prof_clr)
     ,.core_reset_n_o (core_reset_n_o)
     );

   // address translation
   bridge_addr_translate #
     (.dram_limit_p(dram_limit_p))
   xlate
     (.aclk_i           (aclk_i)
     ,.rst_n_i          (rst_n_i)
     ,.host_addr_v_i    (host_addr_v_i)
     ,.host_addr_i      (host_addr_i)
     ,.core_addr_v_o    (core_addr_v_o)
     ,.core_addr_o      (core_addr_o)
     ,.dram_v_i         (dram_v_i)
     ,.dram_addr_i      (dram_addr_i)
     ,.base_addr_i      (base_addr)
     ,.ps_addr_v_o      (ps_addr_v_o)
     ,.ps_addr_o        (ps_addr_o)
     ,.dram_range_err_o (dram_range_err_o)
     );

   // memory profiling sees the same dram requests as the translator
   bridge_mem_profiler prof
     (.aclk_i      (aclk_i)
     ,.rst_n_i     (rst_n_i)
     ,.core_run_i  (core_run)
     ,.dram_v_i    (dram_v_i)
     ,.dram_addr_i (dram_addr_i)
     ,.prof_sel_i  (prof_sel)
     ,.prof_clr_i  (prof_clr)
     ,.prof_word_o (prof_word)
     );

endmodule

// ==== source/bridge_mem_profiler.sv ====
`timescale 1ns/1ps

module bridge_mem_profiler
   import bridge_pkg::*;
   (
    input  logic       aclk_i
   ,input  logic       rst_n_i

    // the profiler runs only while the core is out of reset
   ,input  logic       core_run_i

    // dram requests from the core
   ,input  logic       dram_v_i
   ,input  dram_addr_u dram_addr_i

    // host readout and clear
   ,input  logic [1:0] prof_sel_i
   ,input  logic       prof_clr_i
   ,output csr_word_t  prof_word_o
   );

   // one sticky bit per region touched since the last clear
   logic [PROF_REGIONS-1:0] bitmap_r;

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         bitmap_r <= '0;
      // a clear wins over a request in the same cycle
      else if (prof_clr_i || !core_run_i)
         bitmap_r <= '0;
      else if (dram_v_i)
         bitmap_r[dram_addr_i.fields.region] <= 1'b1;
   end

   // the selected quarter goes straight back to the apb read mux
   assign prof_word_o = bitmap_r[{prof_sel_i, 5'b0} +: 32];

   // a host clear empties the whole map by the following cycle
   clear_empties_map: assert property (
      @(posedge aclk_i) disable iff (!rst_n_i)
      prof_clr_i |=> (bitmap_r == '0)
   );

endmodule

// ==== source/bridge_addr_translate.sv ====
`timescale 1ns/1ps

module bridge_addr_translate
   import bridge_pkg::*;
   #(
     parameter int unsigned dram_limit_p = 64*1024*1024
   )
   (
    input  logic       aclk_i
   ,input  logic       rst_n_i

    // host window port, one address per cycle
   ,input  logic       host_addr_v_i
   ,input  host_addr_t host_addr_i
   ,output logic       core_addr_v_o
   ,output core_addr_t core_addr_o

    // core dram port, one request per cycle
   ,input  logic       dram_v_i
   ,input  dram_addr_u dram_addr_i
   ,input  ps_addr_t   base_addr_i
   ,output logic       ps_addr_v_o
   ,output ps_addr_t   ps_addr_o
   ,output logic       dram_range_err_o
   );

   core_addr_t host_wide;
   core_addr_t host_offset;
   core_addr_t dram_off;

   // the lower window lands in core dram and the upper window in core local space
   // both are a single bit flip of the incoming address
   assign host_wide   = core_addr_t'(host_addr_i);
   assign host_offset = (host_wide > HOST_WIN_SPLIT) ? HOST_WIN_SPLIT : CORE_DRAM_BASE;

   // dropping the core dram base leaves the byte offset into the allocated block
   assign dram_off = dram_addr_i.raw ^ CORE_DRAM_BASE;

   // valids and the range flag trail their requests by one cycle
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         core_addr_v_o    <= 1'b0;
         ps_addr_v_o      <= 1'b0;
         dram_range_err_o <= 1'b0;
      end
      else
      begin
         core_addr_v_o    <= host_addr_v_i;
         ps_addr_v_o      <= dram_v_i;
         // anything past the allocated size points outside the host buffer
         dram_range_err_o <= dram_v_i & (dram_off > dram_limit_p);
      end
   end

   // address payloads only load when their valid is high
   always_ff @(posedge aclk_i)
   begin
      if (host_addr_v_i)
         core_addr_o <= host_wide ^ host_offset;
      if (dram_v_i)
         ps_addr_o <= dram_off + base_addr_i;
   end

   // the flag only means something alongside a rebased address
   range_err_with_valid: assert property (
      @(posedge aclk_i) disable iff (!rst_n_i)
      dram_range_err_o |-> ps_addr_v_o
   );

endmodule

// ==== source/bridge_csr_decode.sv ====
`timescale 1ns/1ps

module bridge_csr_decode
   import bridge_pkg::*;
   (
    input  logic      aclk_i
   ,input  logic      rst_n_i

    // apb slave
   ,input  logic      psel_i
   ,input  logic      penable_i
   ,input  logic      pwrite_i
   ,input  apb_addr_t paddr_i
   ,input  csr_word_t pwdata_i
   ,output csr_word_t prdata_o
   ,output logic      pready_o
   ,output logic      pslverr_o

    // profiler word readback
   ,input  csr_word_t prof_word_i

    // control outputs to the rest of the bridge
   ,output logic      core_run_o
   ,output ps_addr_t  base_addr_o
   ,output logic [1:0] prof_sel_o
   ,output logic      prof_clr_o
   ,output logic      core_reset_n_o
   );

   logic      access;
   logic      mapped;
   logic      is_prof;
   logic      is_clr;
   logic      slv_err;
   logic      wr_ok;
   csr_word_t rd_data;

   // run bit releases the core, alloc tells software the dram is ready
   logic      run_r;
   logic      alloc_r;
   ps_addr_t  base_r;

   // the access phase is the second cycle of every transfer
   assign access = psel_i & penable_i;

   // register decode and read mux share one case on the address
   always_comb
   begin
      mapped  = 1'b1;
      is_prof = 1'b0;
      is_clr  = 1'b0;
      rd_data = '0;
      case (paddr_i)
         REG_RUN:   rd_data = csr_word_t'(run_r);
         REG_ALLOC: rd_data = csr_word_t'(alloc_r);
         REG_BASE:  rd_data = base_r;
         REG_PROF0, REG_PROF1, REG_PROF2, REG_PROF3:
         begin
            is_prof = 1'b1;
            rd_data = prof_word_i;
         end
         // the clear register is write only and reads as zero
         REG_PROF_CLR: is_clr = 1'b1;
         default:      mapped = 1'b0;
      endcase
   end

   // profiler words are read only and the clear register is write only
   assign slv_err = access & (~mapped | (pwrite_i & is_prof) | (~pwrite_i & is_clr));

   // a failed write leaves every register as it was
   assign wr_ok = access & pwrite_i & ~slv_err;

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         run_r   <= 1'b0;
         alloc_r <= 1'b0;
         base_r  <= '0;
      end
      else if (wr_ok)
      begin
         case (paddr_i)
            REG_RUN:   run_r   <= pwdata_i[0];
            REG_ALLOC: alloc_r <= pwdata_i[0];
            REG_BASE:  base_r  <= pwdata_i;
            default:   run_r   <= run_r;
         endcase
      end
   end

   // no wait states so ready simply tracks the access phase
   assign pready_o  = access;
   assign pslverr_o = slv_err;
   assign prdata_o  = rd_data;

   // REG_PROF0 sits on a 16-byte boundary so bits 3:2 pick the word
   assign prof_sel_o = paddr_i[3:2];

   // the pulse lasts exactly the access phase of the write
   assign prof_clr_o = access & pwrite_i & is_clr & pwdata_i[0];

   assign core_run_o  = run_r;
   assign base_addr_o = base_r;

   // run_r clears asynchronously, so the core stays in reset with rst_n_i low
   assign core_reset_n_o = run_r;

   // a master must select the slave before it enters the access phase
   penable_needs_psel: assert property (
      @(posedge aclk_i) disable iff (!rst_n_i)
      $rose(penable_i) |-> psel_i
   );

endmodule

// ==== source/bridge_pkg.sv ====
package bridge_pkg;

   // apb register port is a 32-bit word on a 6-bit byte address
   typedef logic [31:0] csr_word_t;
   typedef logic [5:0]  apb_addr_t;

   // the host window port loses its top two address bits on the way in
   typedef logic [29:0] host_addr_t;

   // core physical and host dram addresses are both full 32-bit words
   typedef logic [31:0] core_addr_t;
   typedef logic [31:0] ps_addr_t;

   // core dram address with two views
   // the raw word feeds the rebase and the range check
   // the field view gives the profiler its region number
   typedef union packed
   {
      core_addr_t raw;
      struct packed
      {
         logic [1:0]  upper;
         logic [6:0]  region;
         logic [22:0] offset;
      } fields;
   } dram_addr_u;

   // core dram starts at 2 GB and the host window toggles this bit away
   localparam core_addr_t CORE_DRAM_BASE = 32'h8000_0000;

   // host addresses above this point reach core local space
   localparam core_addr_t HOST_WIN_SPLIT = 32'h2000_0000;

   // control register map
   localparam apb_addr_t REG_RUN      = 6'h00;
   localparam apb_addr_t REG_ALLOC    = 6'h04;
   localparam apb_addr_t REG_BASE     = 6'h08;
   localparam apb_addr_t REG_PROF0    = 6'h10;
   localparam apb_addr_t REG_PROF1    = 6'h14;
   localparam apb_addr_t REG_PROF2    = 6'h18;
   localparam apb_addr_t REG_PROF3    = 6'h1C;
   localparam apb_addr_t REG_PROF_CLR = 6'h20;

   // one bitmap bit per 8 MB region of the 1 GB window under bits 29:23
   localparam int unsigned PROF_REGIONS = 128;

endpackage
